// File: hw/xc_cfg_pkg.sv
/* Line count, field widths, LED option and the baud divisor table. */

package xc_cfg_pkg;

	localparam int num_lines     = 4;
	localparam int line_w        = 8; // Width of the current line pointer.
	localparam int line_sel_w    = $clog2(num_lines);
	localparam int tap_w         = 3;
	localparam int taps_per_line = 4;
	localparam int idx_w         = tap_w * taps_per_line; // 12 index bits per line.
	localparam int volt_w        = 8;
	localparam int nib_w         = 4; // Test, LED, divider and baud fields.
	localparam bit has_leds      = 1'b1;

	// Prescaler width, enough for a divide by 2**15.
	localparam int pre_w = 2 ** nib_w - 1;

	// Cycles per bit, indexed by baud_sel. Short on purpose.
	localparam int baud_cnt_w = 9;
	localparam logic [baud_cnt_w-1:0] baud_div [16] = '{
		9'd16,  9'd32,  9'd48,  9'd64,
		9'd80,  9'd96,  9'd112, 9'd128,
		9'd144, 9'd160, 9'd176, 9'd192,
		9'd208, 9'd224, 9'd240, 9'd256
	};

endpackage

// File: hw/xc_cmd_pkg.sv
/* Command opcodes, field positions and the packed union that decodes one command byte. */

package xc_cmd_pkg;

	localparam logic [3:0] op_clear          = 4'd0;
	localparam logic [3:0] op_set_line       = 4'd1;
	localparam logic [3:0] op_set_leds       = 4'd2;
	localparam logic [3:0] op_set_baud       = 4'd3;
	localparam logic [3:0] op_set_delay      = 4'd4; // Base of opcodes 4 to 7.
	localparam logic [3:0] op_set_freq_div   = 4'd8;
	localparam logic [3:0] op_set_voltage    = 4'd9;
	localparam logic [3:0] op_enable_test    = 4'd12;
	localparam logic [3:0] op_enable_capture = 4'd13;

	// Opcodes 4 to 7 share their upper two bits.
	localparam logic [1:0] delay_group = op_set_delay[3:2];

	localparam int chunk_w = 2; // Bits written by one SET_LINE or SET_VOLTAGE.

	typedef struct packed {
		logic [chunk_w-1:0] sel; // Chunk position, scaled by chunk_w.
		logic [chunk_w-1:0] val; // Chunk payload.
	} cmd_arg_t;

	typedef struct packed {
		cmd_arg_t   arg;    // Bits 7:4.
		logic [3:0] opcode; // Bits 3:0.
	} cmd_gen_t;

	typedef struct packed {
		logic       is_auto;   // Bit 7, auto index when set.
		logic [2:0] tap_value; // Bits 6:4.
		logic [1:0] group;     // Bits 3:2, equal to delay_group.
		logic [1:0] tap_sel;   // Bits 1:0, tap within the line.
	} cmd_dly_t;

	// Same byte, two decodings.
	typedef union packed {
		cmd_gen_t gen;
		cmd_dly_t dly;
	} cmd_word_t;

endpackage

// File: hw/uart_rx.sv
/* 8N1 serial receiver, divisor picked from the baud table at each start bit. */

module uart_rx (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         rxd,
	input  logic [xc_cfg_pkg::nib_w-1:0] baud_sel,
	output logic                         rx_valid,
	output logic [7:0]                   rx_byte
);

	logic                              rxd_meta;  // First sync stage.
	logic                              rxd_sync;  // Second sync stage.
	logic                              rxd_prev;  // For falling edge detect.
	logic                              busy;      // Frame in progress.
	logic [3:0]                        bit_idx;   // 0 start, 1..8 data, 9 stop.
	logic [xc_cfg_pkg::baud_cnt_w-1:0] cnt;       // Cycles into current bit.
	logic [xc_cfg_pkg::baud_cnt_w-1:0] bit_len;   // Latched at start edge.
	logic [xc_cfg_pkg::baud_cnt_w-1:0] half_m1;   // Last cycle of half a bit.
	logic [xc_cfg_pkg::baud_cnt_w-1:0] full_m1;   // Last cycle of a full bit.
	logic [7:0]                        shreg;     // LSB first shift register.
	logic                              start_edge;

	assign start_edge = rxd_prev & ~rxd_sync;
	assign half_m1    = (bit_len >> 1) - 1'b1;
	assign full_m1    = bit_len - 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1; // Line idles high.
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			bit_idx  <= 4'd0;
			cnt      <= '0;
			bit_len  <= xc_cfg_pkg::baud_div[0];
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0; // Single cycle strobe.
			if (!busy) begin
				if (start_edge) begin
					busy    <= 1'b1;
					bit_idx <= 4'd0;
					cnt     <= '0;
					bit_len <= xc_cfg_pkg::baud_div[baud_sel]; // New rate per frame.
				end
			end else if (bit_idx == 4'd0) begin
				if (cnt == half_m1) begin
					cnt <= '0;
					if (rxd_sync)
						busy <= 1'b0; // Glitch, not a start bit.
					else
						bit_idx <= 4'd1; // Now aligned to mid-bit.
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (cnt == full_m1) begin
				cnt <= '0;
				if (bit_idx == 4'd9) begin
					busy     <= 1'b0;
					rx_valid <= rxd_sync; // Framing error drops the byte.
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Payload path.
	always_ff @(posedge clk) begin
		if (busy && bit_idx != 4'd0 && cnt == full_m1) begin
			if (bit_idx == 4'd9) begin
				if (rxd_sync)
					rx_byte <= shreg; // Held until next valid byte.
			end else begin
				shreg <= {rxd_sync, shreg[7:1]};
			end
		end
	end

endmodule

// File: hw/cmd_parser.sv
/* Command decoder and register file for per-line and global correlator settings. */

module cmd_parser (
	input  logic                                                   clk,
	input  logic                                                   rst_n,
	input  logic                                                   rx_valid,
	input  logic [7:0]                                             rx_byte,
	output logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::volt_w-1:0]   voltage_pwm,
	output logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::nib_w-1:0]    test,
	output logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::nib_w-1:0]    leds,
	output logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::idx_w-1:0]    cross_idx,
	output logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::idx_w-1:0]    auto_idx,
	output logic [xc_cfg_pkg::nib_w-1:0]                           clock_divider,
	output logic [xc_cfg_pkg::nib_w-1:0]                           baud_sel,
	output logic [xc_cfg_pkg::line_w-1:0]                          current_line,
	output logic                                                   integrating,
	output logic                                                   external_clock,
	output logic                                                   timestamp_reset
);

	xc_cmd_pkg::cmd_word_t                 cmd;     // Byte seen through both views.
	logic [xc_cfg_pkg::line_sel_w-1:0]     sel;     // Narrow line index.
	logic                                  line_ok; // Pointer names a real line.
	logic                                  is_dly;  // Opcode in 4..7.

	assign cmd     = rx_byte;
	assign sel     = current_line[xc_cfg_pkg::line_sel_w-1:0];
	assign line_ok = current_line < xc_cfg_pkg::num_lines;
	assign is_dly  = cmd.dly.group == xc_cmd_pkg::delay_group;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			voltage_pwm     <= '0;
			test            <= '0;
			leds            <= '0;
			cross_idx       <= '0;
			auto_idx        <= '0;
			clock_divider   <= '0;
			baud_sel        <= '0; // Receiver starts at table entry 0.
			current_line    <= '0;
			integrating     <= 1'b0;
			external_clock  <= 1'b0;
			timestamp_reset <= 1'b1; // Timestamps held until capture enabled.
		end else if (rx_valid) begin
			if (is_dly) begin
				if (line_ok) begin
					if (cmd.dly.is_auto)
						auto_idx[sel*xc_cfg_pkg::idx_w + cmd.dly.tap_sel*xc_cfg_pkg::tap_w
							+: xc_cfg_pkg::tap_w] <= cmd.dly.tap_value;
					else
						cross_idx[sel*xc_cfg_pkg::idx_w + cmd.dly.tap_sel*xc_cfg_pkg::tap_w
							+: xc_cfg_pkg::tap_w] <= cmd.dly.tap_value;
				end
			end else begin
				case (cmd.gen.opcode)
					xc_cmd_pkg::op_clear: begin
						if (line_ok) begin
							cross_idx[sel*xc_cfg_pkg::idx_w +: xc_cfg_pkg::idx_w] <= '0;
							auto_idx[sel*xc_cfg_pkg::idx_w +: xc_cfg_pkg::idx_w]  <= '0;
						end
					end
					xc_cmd_pkg::op_set_line: begin
						// Pointer built two bits at a time.
						current_line[cmd.gen.arg.sel*xc_cmd_pkg::chunk_w +: xc_cmd_pkg::chunk_w]
							<= cmd.gen.arg.val;
					end
					xc_cmd_pkg::op_set_leds: begin
						if (xc_cfg_pkg::has_leds && line_ok)
							leds[sel*xc_cfg_pkg::nib_w +: xc_cfg_pkg::nib_w] <= cmd.gen.arg;
					end
					xc_cmd_pkg::op_set_baud: begin
						baud_sel <= cmd.gen.arg; // Applies from the next start bit.
					end
					xc_cmd_pkg::op_set_freq_div: begin
						clock_divider <= cmd.gen.arg;
					end
					xc_cmd_pkg::op_set_voltage: begin
						if (line_ok)
							voltage_pwm[sel*xc_cfg_pkg::volt_w
								+ cmd.gen.arg.sel*xc_cmd_pkg::chunk_w +: xc_cmd_pkg::chunk_w]
								<= cmd.gen.arg.val;
					end
					xc_cmd_pkg::op_enable_test: begin
						if (line_ok)
							test[sel*xc_cfg_pkg::nib_w +: xc_cfg_pkg::nib_w] <= cmd.gen.arg;
					end
					xc_cmd_pkg::op_enable_capture: begin
						integrating     <= cmd.gen.arg[0];
						external_clock  <= cmd.gen.arg[1];
						timestamp_reset <= cmd.gen.arg[2];
					end
					default: begin
						// Opcodes 10, 11, 14 and 15 are reserved.
					end
				endcase
			end
		end
	end

endmodule

// File: hw/pwm_bank.sv
/* PWM generators, one per line, driven from a shared prescaled 8-bit counter. */

module pwm_bank (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::volt_w-1:0] voltage_pwm,
	input  logic [xc_cfg_pkg::nib_w-1:0]                         clock_divider,
	output logic [xc_cfg_pkg::num_lines-1:0]                     pwm
);

	logic [xc_cfg_pkg::pre_w-1:0]  pre_cnt; // Free running prescaler.
	logic [xc_cfg_pkg::pre_w-1:0]  mask;    // Low bits that must all be set.
	logic                          tick;    // One per 2**clock_divider cycles.
	logic [xc_cfg_pkg::volt_w-1:0] step;    // Shared PWM phase.

	// A shift by 15 wraps to zero, so the mask becomes all ones.
	assign mask = ({{(xc_cfg_pkg::pre_w-1){1'b0}}, 1'b1} << clock_divider) - 1'b1;
	assign tick = (pre_cnt & mask) == mask;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre_cnt <= '0;
			step    <= '0;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
			if (tick)
				step <= step + 1'b1; // Wraps after 256 ticks.
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pwm <= '0;
		end else begin
			for (int i = 0; i < xc_cfg_pkg::num_lines; i++) begin
				// Duty 0 never high, 255 high on 255 of 256 steps.
				pwm[i] <= step < voltage_pwm[i*xc_cfg_pkg::volt_w +: xc_cfg_pkg::volt_w];
			end
		end
	end

endmodule

// File: hw/xc_ctrl_top.sv
/* Correlator control front end: UART receiver, command parser and PWM bank. */

module xc_ctrl_top (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  logic                                                rxd,
	output logic [xc_cfg_pkg::num_lines-1:0]                    pwm,
	output logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::nib_w-1:0] test,
	output logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::nib_w-1:0] leds,
	output logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::idx_w-1:0] cross_idx,
	output logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::idx_w-1:0] auto_idx,
	output logic [xc_cfg_pkg::nib_w-1:0]                        clock_divider,
	output logic [xc_cfg_pkg::nib_w-1:0]                        baud_sel,
	output logic [xc_cfg_pkg::line_w-1:0]                       current_line,
	output logic                                                integrating,
	output logic                                                external_clock,
	output logic                                                timestamp_reset
);

	logic                                                 rx_valid;    // Byte strobe.
	logic [7:0]                                           rx_byte;     // Received command.
	logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::volt_w-1:0] voltage_pwm; // Duties to PWM.

	uart_rx u_rx (
		.clk      (clk),
		.rst_n    (rst_n),
		.rxd      (rxd),
		.baud_sel (baud_sel), // Fed back from the parser.
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	cmd_parser u_parser (
		.clk             (clk),
		.rst_n           (rst_n),
		.rx_valid        (rx_valid),
		.rx_byte         (rx_byte),
		.voltage_pwm     (voltage_pwm),
		.test            (test),
		.leds            (leds),
		.cross_idx       (cross_idx),
		.auto_idx        (auto_idx),
		.clock_divider   (clock_divider),
		.baud_sel        (baud_sel),
		.current_line    (current_line),
		.integrating     (integrating),
		.external_clock  (external_clock),
		.timestamp_reset (timestamp_reset)
	);

	pwm_bank u_pwm (
		.clk           (clk),
		.rst_n         (rst_n),
		.voltage_pwm   (voltage_pwm),
		.clock_divider (clock_divider),
		.pwm           (pwm)
	);

endmodule

// File: sim/tb_clock_gen.sv
/* Testbench clock source, period of 100 time units. */

module tb_clock_gen (
	output logic clk
);

	initial clk = 1'b0; // Starts low, first rising edge at 50.

	always #50 clk = ~clk;

endmodule

// File: sim/xc_ctrl_sva.sv
/* Concurrent checks on the control front end and their bind into xc_ctrl_top. */

module xc_ctrl_sva (
	input logic                                                 clk,
	input logic                                                 rst_n,
	input logic                                                 rx_valid,
	input logic [7:0]                                           rx_byte,
	input logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::volt_w-1:0] voltage_pwm,
	input logic [xc_cfg_pkg::num_lines-1:0]                     pwm,
	input logic [xc_cfg_pkg::num_lines*xc_cfg_pkg::volt_w
		+ 2*xc_cfg_pkg::num_lines*xc_cfg_pkg::nib_w
		+ 2*xc_cfg_pkg::num_lines*xc_cfg_pkg::idx_w
		+ 2*xc_cfg_pkg::nib_w + xc_cfg_pkg::line_w + 2:0]     outs // Parser outputs, ts_reset LSB.
);

	xc_cmd_pkg::cmd_word_t cmd;     // Received byte, generic view used.
	logic                  seen_rx; // First byte taken.

	assign cmd = rx_byte;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			seen_rx <= 1'b0;
		else if (rx_valid)
			seen_rx <= 1'b1;
	end

	// Only timestamp_reset comes out of reset high.
	reset_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_rx |-> ((outs >> 1) == '0 && outs[0]))
		else $error("outputs left their reset values before the first byte");

	single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		rx_valid |=> !rx_valid)
		else $error("rx_valid high for two cycles in a row");

	change_after_byte: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(outs) |-> $past(rx_valid))
		else $error("parser output changed without a received byte");

	reserved_nop: assert property (@(posedge clk) disable iff (!rst_n)
		(rx_valid && (cmd.gen.opcode inside {4'd10, 4'd11, 4'd14, 4'd15})) |=> $stable(outs))
		else $error("reserved opcode changed an output");

	for (genvar i = 0; i < xc_cfg_pkg::num_lines; i++) begin : g_pwm
		// Duty seen by the comparator is the one from the previous edge.
		pwm_zero_duty: assert property (@(posedge clk) disable iff (!rst_n)
			$rose(pwm[i]) |-> $past(voltage_pwm[i*xc_cfg_pkg::volt_w +: xc_cfg_pkg::volt_w]) != '0)
			else $error("pwm rose while its duty was zero");
	end

endmodule

bind xc_ctrl_top xc_ctrl_sva u_sva (
	.clk         (clk),
	.rst_n       (rst_n),
	.rx_valid    (rx_valid),
	.rx_byte     (rx_byte),
	.voltage_pwm (voltage_pwm),
	.pwm         (pwm),
	.outs        ({voltage_pwm, test, leds, cross_idx, auto_idx, clock_divider,
		baud_sel, current_line, integrating, external_clock, timestamp_reset})
);

// File: sim/xc_ctrl_tb.sv
/* Testbench for xc_ctrl_top with serial byte driver, settings model,
   immediate checks and watchdog. */

module xc_ctrl_tb;

	localparam int     clk_period    = 100;
	localparam int     num_bytes     = 104; // Bytes sent by all behaviors.
	// 48 cycles per bit at baud entry 2, the slowest rate used.
	localparam longint watchdog_time = longint'(num_bytes) * 10 * 48 * clk_period + 20000;

	logic        clk, rst_n, rxd;
	logic [3:0]  pwm, clock_divider, baud_sel;
	logic [15:0] test, leds;
	logic [47:0] cross_idx, auto_idx;
	logic [7:0]  current_line;
	logic        integrating, external_clock, timestamp_reset;

	logic [7:0]  m_volt [4];     // Model of the per-line settings.
	logic [3:0]  m_test [4];
	logic [3:0]  m_leds [4];
	logic [2:0]  m_cross [4][4]; // [line][tap].
	logic [2:0]  m_auto [4][4];
	logic [3:0]  m_div, m_baud;
	logic [7:0]  m_line;
	logic        m_integ, m_ext, m_ts;
	logic [3:0]  tb_baud;        // Baud select the driver uses.
	logic [3:0]  reserved [4] = '{4'd10, 4'd11, 4'd14, 4'd15};
	logic [7:0]  duties [3]   = '{8'd0, 8'd128, 8'd255};

	tb_clock_gen u_clk (.clk(clk));

	xc_ctrl_top dut0 (.*);

	task automatic fail_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
		assert (act_v === exp_v) else begin
			$display("[ERROR] %s expected %h actual %h", name, exp_v, act_v);
			fail_run();
		end
	endtask

	task automatic reset_model();
		for (int l = 0; l < 4; l++) begin
			m_volt[l] = '0;
			m_test[l] = '0;
			m_leds[l] = '0;
			for (int t = 0; t < 4; t++) begin
				m_cross[l][t] = '0;
				m_auto[l][t]  = '0;
			end
		end
		{m_div, m_baud, m_line, m_integ, m_ext} = '0;
		m_ts = 1'b1; // Timestamps held in reset.
	endtask

	// Rules per command byte, arg in the upper nibble.
	task automatic apply_model(input logic [7:0] b);
		logic [3:0] arg;
		int         ln;
		arg = b[7:4];
		ln  = int'(m_line);
		if (b[3:2] == 2'b01) begin // Opcodes 4 to 7.
			if (ln < 4 && b[7])
				m_auto[ln][b[1:0]] = b[6:4];
			else if (ln < 4)
				m_cross[ln][b[1:0]] = b[6:4];
		end else begin
			case (b[3:0])
				4'd0: if (ln < 4) begin
					for (int t = 0; t < 4; t++) begin
						m_cross[ln][t] = '0;
						m_auto[ln][t]  = '0;
					end
				end
				4'd1: m_line[arg[3:2]*2 +: 2] = arg[1:0];
				4'd2: if (xc_cfg_pkg::has_leds && ln < 4) m_leds[ln] = arg;
				4'd3: m_baud = arg;
				4'd8: m_div = arg;
				4'd9: if (ln < 4) m_volt[ln][arg[3:2]*2 +: 2] = arg[1:0];
				4'd12: if (ln < 4) m_test[ln] = arg;
				4'd13: {m_ts, m_ext, m_integ} = arg[2:0];
				default: ; // Reserved.
			endcase
		end
	endtask

	task automatic check_all();
		logic [31:0] e_volt;
		logic [15:0] e_test, e_leds;
		logic [47:0] e_cross, e_auto;
		for (int l = 0; l < 4; l++) begin
			e_volt[l*8 +: 8] = m_volt[l];
			e_test[l*4 +: 4] = m_test[l];
			e_leds[l*4 +: 4] = m_leds[l];
			for (int t = 0; t < 4; t++) begin
				e_cross[l*12 + t*3 +: 3] = m_cross[l][t];
				e_auto[l*12 + t*3 +: 3]  = m_auto[l][t];
			end
		end
		check_val("voltage_pwm", 64'(e_volt), 64'(dut0.voltage_pwm));
		check_val("test", 64'(e_test), 64'(test));
		check_val("leds", 64'(e_leds), 64'(leds));
		check_val("cross_idx", 64'(e_cross), 64'(cross_idx));
		check_val("auto_idx", 64'(e_auto), 64'(auto_idx));
		check_val("clock_divider", 64'(m_div), 64'(clock_divider));
		check_val("baud_sel", 64'(m_baud), 64'(baud_sel));
		check_val("current_line", 64'(m_line), 64'(current_line));
		check_val("integrating", 64'(m_integ), 64'(integrating));
		check_val("external_clock", 64'(m_ext), 64'(external_clock));
		check_val("timestamp_reset", 64'(m_ts), 64'(timestamp_reset));
	endtask

	// 8N1 frame, then wait for the strobe and compare two cycles later.
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int         bit_cyc;
		frame   = {1'b1, b, 1'b0};
		bit_cyc = int'(xc_cfg_pkg::baud_div[tb_baud]);
		@(posedge clk);
		#10;
		for (int i = 0; i < 9; i++) begin
			rxd = frame[i];
			repeat (bit_cyc) @(posedge clk);
			#10;
		end
		rxd = 1'b1; // Stop bit, line then idles.
		do @(negedge clk); while (!dut0.rx_valid);
		apply_model(b);
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_all();
		tb_baud = m_baud; // Next frame at the new rate.
	endtask

	task automatic set_line(input logic [7:0] n);
		for (int k = 0; k < 4; k++)
			send_byte({k[1:0], n[k*2 +: 2], xc_cmd_pkg::op_set_line});
	endtask

	task automatic set_volt(input logic [7:0] v);
		for (int k = 0; k < 4; k++)
			send_byte({k[1:0], v[k*2 +: 2], xc_cmd_pkg::op_set_voltage});
	endtask

	initial begin
		#(watchdog_time);
		$display("Timeout: the command sequence did not complete in time.");
		fail_run();
	end

	initial begin
		int hi [4];
		void'($urandom(32'hde41934d));
		rxd     = 1'b1;
		rst_n   = 1'b0;
		tb_baud = 4'd0;
		reset_model();
		repeat (4) @(posedge clk);
		#10 rst_n = 1'b1;
		@(negedge clk);
		check_all(); // Reset values.
		check_val("pwm", 64'(4'b0), 64'(pwm));
		for (int l = 0; l < 4; l++) begin
			set_line(8'(l));
			send_byte({4'($urandom), xc_cmd_pkg::op_enable_test});
			send_byte({4'($urandom), xc_cmd_pkg::op_set_leds});
			set_volt(8'($urandom));
		end
		set_line(8'd4); // Aliases line 0 if the range check fails.
		send_byte({4'hf, xc_cmd_pkg::op_enable_test});
		send_byte({4'hf, xc_cmd_pkg::op_set_leds});
		send_byte({4'b0011, xc_cmd_pkg::op_set_voltage});
		for (int l = 0; l < 2; l++) begin
			set_line(8'(l));
			for (int t = 0; t < 8; t++)
				send_byte({t[0], 3'($urandom), 2'b01, t[2:1]});
		end
		send_byte({4'd0, xc_cmd_pkg::op_clear}); // Line 1 only.
		set_line(8'h44);
		send_byte(8'hf5);
		send_byte({4'd0, xc_cmd_pkg::op_clear});
		for (int k = 0; k < 3; k++)
			send_byte({4'($urandom), xc_cmd_pkg::op_enable_capture});
		send_byte({4'($urandom), xc_cmd_pkg::op_set_freq_div});
		for (int k = 0; k < 4; k++)
			send_byte({4'($urandom), reserved[k]});
		send_byte({4'd2, xc_cmd_pkg::op_set_baud});
		set_line(8'd3);
		send_byte({4'd0, xc_cmd_pkg::op_set_freq_div});
		for (int i = 0; i < 3; i++) begin
			set_volt(duties[i]);
			for (int l = 0; l < 4; l++)
				hi[l] = 0;
			repeat (256) begin
				@(negedge clk);
				for (int l = 0; l < 4; l++)
					hi[l] += int'(pwm[l]);
			end
			for (int l = 0; l < 4; l++) begin
				assert (hi[l] >= int'(m_volt[l]) - 1 && hi[l] <= int'(m_volt[l]) + 1) else begin
					$display("[ERROR] pwm[%0d] high count expected %h actual %h",
						l, m_volt[l], hi[l]);
					fail_run();
				end
			end
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: sources.f
hw/xc_cfg_pkg.sv
hw/xc_cmd_pkg.sv
hw/uart_rx.sv
hw/cmd_parser.sv
hw/pwm_bank.sv
hw/xc_ctrl_top.sv
sim/tb_clock_gen.sv
sim/xc_ctrl_sva.sv
sim/xc_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the correlator control front end testbench.

VERILATOR ?= verilator
TOP       ?= xc_ctrl_tb
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, exit status gives the result"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
